// ==== verilog/mmuPkg.sv ====
`default_nettype none

package mmuPkg;

  // ====================================================================
  // sizes
  // ====================================================================
  localparam int tlbEntries   = 8;
  localparam int tlbIndexBits = 3;
  // va/pa bits 31:10 kept per entry
  localparam int tagBits      = 22;

  // walker states
  typedef enum logic [3:0] {
    ready,
    lookup,
    l1Fetch,
    coarseFetch,
    fineFetch,
    translate,
    faultReport
  } walkStateT;

  // page size of one translation
  typedef enum logic [1:0] {
    pageSection,
    pageLarge,
    pageSmall,
    pageTiny
  } pageSizeT;

  // ====================================================================
  // descriptor and fault codes
  // ====================================================================
  // first level type bits [1:0]
  localparam logic [1:0] descFault   = 2'b00;
  localparam logic [1:0] descCoarse  = 2'b01;
  localparam logic [1:0] descSection = 2'b10;
  localparam logic [1:0] descFine    = 2'b11;
  // second level type bits, 00 is descFault again
  localparam logic [1:0] descLarge   = 2'b01;
  localparam logic [1:0] descSmall   = 2'b10;
  localparam logic [1:0] descTiny    = 2'b11;

  // FSR status values
  localparam logic [3:0] fsrSectionFault = 4'b0101;
  localparam logic [3:0] fsrPageFault    = 4'b0111;

  // tag bits that belong to the page base for a given size
  function automatic logic [tagBits-1:0] pageMask(input pageSizeT size);
    case (size)
      pageSection: pageMask = {{12{1'b1}}, {10{1'b0}}};
      pageLarge:   pageMask = {{16{1'b1}}, {6{1'b0}}};
      pageSmall:   pageMask = {{20{1'b1}}, {2{1'b0}}};
      default:     pageMask = {tagBits{1'b1}};
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== verilog/tableWalker.sv ====
`default_nettype none

module tableWalker (
  input  logic              clk,
  input  logic              reset,
  input  logic              mmuEnable,
  input  logic              cpuRequest,
  input  logic              dataAccess,
  input  logic              tlbHit,
  input  logic              busReady,
  input  logic [31:0]       busRData,
  output mmuPkg::walkStateT state,
  output logic              busy,
  output logic              busRequest,
  output logic              tlbWrite,
  output logic              paReady,
  output logic              prefetchAbort,
  output logic              dataAbort,
  output logic              faultWrite,
  output logic [3:0]        faultCode
);

  import mmuPkg::*;

  walkStateT  nextState;
  logic       accept;
  logic       busDone;
  logic       isData;
  logic [1:0] descType;

  // ====================================================================
  // handshake terms
  // ====================================================================
  // strobe only taken while idle
  assign accept   = cpuRequest && (state == ready);
  // type bits of whatever descriptor is on the bus
  assign descType = busRData[1:0];
  // descriptor transfer completes this cycle
  assign busDone  = busRequest && busReady;

  // state register
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= ready;
    end else begin
      state <= nextState;
    end
  end

  // access kind and fault code, only read after acceptance
  always_ff @(posedge clk) begin
    if (accept)
      isData <= dataAccess;
    // first level fault is a section fault, anything later a page fault
    if (busDone && (descType == descFault))
      faultCode <= (state == l1Fetch) ? fsrSectionFault : fsrPageFault;
  end

  // ====================================================================
  // next state
  // ====================================================================
  always_comb begin
    nextState = state;
    case (state)
      ready: begin
        if (accept)
          nextState = lookup;
      end
      lookup: begin
        // flat mapping or TLB hit ends here
        if (!mmuEnable || tlbHit)
          nextState = ready;
        else
          nextState = l1Fetch;
      end
      l1Fetch: begin
        // busReady low just holds us here
        if (busReady) begin
          case (descType)
            descCoarse:  nextState = coarseFetch;
            descSection: nextState = translate;
            descFine:    nextState = fineFetch;
            default:     nextState = faultReport;
          endcase
        end
      end
      coarseFetch, fineFetch: begin
        // any nonzero second level type is a page
        if (busReady) begin
          if (descType == descFault)
            nextState = faultReport;
          else
            nextState = translate;
        end
      end
      translate:   nextState = ready;
      faultReport: nextState = ready;
      default:     nextState = ready;
    endcase
  end

  // ====================================================================
  // outputs
  // ====================================================================
  assign busy       = (state != ready);
  assign busRequest = (state == l1Fetch) || (state == coarseFetch) || (state == fineFetch);

  // one cycle in translate fills the TLB
  assign tlbWrite = (state == translate);

  // hit/flat result in lookup, walked result in translate
  assign paReady = ((state == lookup) && (!mmuEnable || tlbHit)) || (state == translate);

  // data faults go to FSR/FAR, instruction faults only abort
  assign dataAbort     = (state == faultReport) && isData;
  assign faultWrite    = (state == faultReport) && isData;
  assign prefetchAbort = (state == faultReport) && !isData;

endmodule

`default_nettype wire

// ==== verilog/walkAddrGen.sv ====
`default_nettype none

module walkAddrGen (
  input  logic                       clk,
  input  logic                       reset,
  input  mmuPkg::walkStateT          state,
  input  logic                       cpuRequest,
  input  logic                       busy,
  input  logic [31:0]                cpuAddr,
  input  logic [17:0]                tBase,
  input  logic [31:0]                busRData,
  input  logic                       busReady,
  input  logic [mmuPkg::tagBits-1:0] hitPhysTag,
  input  mmuPkg::pageSizeT           hitSize,
  input  logic                       mmuEnable,
  output logic [31:0]                virtAddr,
  output logic [31:0]                busAddr,
  output logic [31:0]                physAddr,
  output logic [mmuPkg::tagBits-1:0] fillPhysTag,
  output mmuPkg::pageSizeT           fillSize
);

  import mmuPkg::*;

  logic [31:0] desc;
  logic        secondLevel;
  logic        fetching;

  assign fetching = (state == l1Fetch) || (state == coarseFetch) || (state == fineFetch);

  // page base over the low virtual bits
  function automatic logic [31:0] mergeAddr(input logic [tagBits-1:0] tag,
                                            input pageSizeT size,
                                            input logic [31:0] va);
    logic [tagBits-1:0] mask;
    mask = pageMask(size);
    mergeAddr = {(tag & mask) | (va[31:10] & ~mask), va[9:0]};
  endfunction

  // va on accepted strobe, descriptor on each completed fetch
  always_ff @(posedge clk) begin
    if (cpuRequest && !busy)
      virtAddr <= cpuAddr;
    if (fetching && busReady)
      desc <= busRData;
  end

  // remembers whether desc came from a second level table
  always_ff @(posedge clk, posedge reset) begin
    if (reset)
      secondLevel <= 1'b0;
    else if (fetching && busReady)
      secondLevel <= (state != l1Fetch);
  end

  // descriptor address per fetch state
  always_comb begin
    case (state)
      coarseFetch: busAddr = {desc[31:10], virtAddr[19:12], 2'b00};
      fineFetch:   busAddr = {desc[31:12], virtAddr[19:10], 2'b00};
      default:     busAddr = {tBase, virtAddr[31:20], 2'b00};
    endcase
  end

  // page size for the fill, coarse type 11 taken as tiny
  always_comb begin
    if (!secondLevel) begin
      fillSize = pageSection;
    end else begin
      case (desc[1:0])
        descLarge: fillSize = pageLarge;
        descSmall: fillSize = pageSmall;
        default:   fillSize = pageTiny;
      endcase
    end
  end

  // bits below the page size get masked on use
  assign fillPhysTag = desc[31:10];

  // walked result, TLB result, or flat copy
  always_comb begin
    if (state == translate)
      physAddr = mergeAddr(fillPhysTag, fillSize, virtAddr);
    else if (mmuEnable)
      physAddr = mergeAddr(hitPhysTag, hitSize, virtAddr);
    else
      physAddr = virtAddr;
  end

endmodule

`default_nettype wire

// ==== verilog/tlb.sv ====
`default_nettype none

module tlb (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [31:0]                virtAddr,
  input  logic                       tlbWrite,
  input  logic                       tlbFlush,
  input  logic [mmuPkg::tagBits-1:0] fillPhysTag,
  input  mmuPkg::pageSizeT           fillSize,
  output logic                       tlbHit,
  output logic [mmuPkg::tagBits-1:0] hitPhysTag,
  output mmuPkg::pageSizeT           hitSize
);

  import mmuPkg::*;

  // ====================================================================
  // entry storage
  // ====================================================================
  logic [tlbEntries-1:0]   valid;
  logic [tagBits-1:0]      virtTag [tlbEntries];
  logic [tagBits-1:0]      physTag [tlbEntries];
  pageSizeT                sizes   [tlbEntries];
  logic [tlbIndexBits-1:0] fillPtr;
  logic [tlbEntries-1:0]   match;

  // valid bits and round robin pointer
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      valid   <= '0;
      fillPtr <= '0;
    end else if (tlbFlush) begin
      // flush wins, write dropped, pointer kept
      valid <= '0;
    end else if (tlbWrite) begin
      valid[fillPtr] <= 1'b1;
      fillPtr        <= fillPtr + 1'b1;
    end
  end

  // tags and size of the entry under the pointer
  always_ff @(posedge clk) begin
    if (tlbWrite && !tlbFlush) begin
      virtTag[fillPtr] <= virtAddr[31:10];
      physTag[fillPtr] <= fillPhysTag;
      sizes[fillPtr]   <= fillSize;
    end
  end

  // ====================================================================
  // lookup
  // ====================================================================
  // compare only the bits above the entry's page size
  always_comb begin
    for (int i = 0; i < tlbEntries; i++) begin
      match[i] = valid[i] &&
                 (((virtTag[i] ^ virtAddr[31:10]) & pageMask(sizes[i])) == '0);
    end
  end

  // lowest matching entry wins
  always_comb begin
    tlbHit     = 1'b0;
    hitPhysTag = '0;
    hitSize    = pageSection;
    for (int i = 0; i < tlbEntries; i++) begin
      if (match[i] && !tlbHit) begin
        tlbHit     = 1'b1;
        hitPhysTag = physTag[i];
        hitSize    = sizes[i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/faultRegs.sv ====
`default_nettype none

module faultRegs (
  input  logic        clk,
  input  logic        reset,
  input  logic        faultWrite,
  input  logic [3:0]  faultCode,
  input  logic [31:0] virtAddr,
  output logic [3:0]  fsr,
  output logic [31:0] far
);

  // ====================================================================
  // CP15 fault status / fault address
  // ====================================================================
  // only data aborts write here, prefetch aborts leave both alone

  // status code
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      fsr <= '0;
    end else if (faultWrite) begin
      // section or page translation fault
      fsr <= faultCode;
    end
  end

  // faulting virtual address
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      far <= '0;
    end else if (faultWrite) begin
      // va still held from the accepted request
      far <= virtAddr;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mmuTop.sv ====
`default_nettype none

module mmuTop (
  input  logic        clk,
  input  logic        reset,
  // cpu side
  input  logic        mmuEnable,
  input  logic        tlbFlush,
  input  logic        cpuRequest,
  input  logic [31:0] cpuAddr,
  input  logic        dataAccess,
  input  logic [17:0] tBase,
  output logic        busy,
  output logic        paReady,
  output logic [31:0] physAddr,
  output logic        prefetchAbort,
  output logic        dataAbort,
  output logic [3:0]  fsr,
  output logic [31:0] far,
  // descriptor read bus
  output logic        busRequest,
  output logic [31:0] busAddr,
  input  logic [31:0] busRData,
  input  logic        busReady
);

  import mmuPkg::*;

  walkStateT          state;
  logic               tlbHit;
  logic               tlbWrite;
  logic               faultWrite;
  logic [3:0]         faultCode;
  logic [31:0]        virtAddr;
  logic [tagBits-1:0] hitPhysTag;
  logic [tagBits-1:0] fillPhysTag;
  pageSizeT           hitSize;
  pageSizeT           fillSize;

  // ====================================================================
  // control
  // ====================================================================
  tableWalker walker (
    .clk(clk), .reset(reset), .mmuEnable(mmuEnable), .cpuRequest(cpuRequest),
    .dataAccess(dataAccess), .tlbHit(tlbHit), .busReady(busReady),
    .busRData(busRData), .state(state), .busy(busy), .busRequest(busRequest),
    .tlbWrite(tlbWrite), .paReady(paReady), .prefetchAbort(prefetchAbort),
    .dataAbort(dataAbort), .faultWrite(faultWrite), .faultCode(faultCode)
  );

  // ====================================================================
  // datapath
  // ====================================================================
  // addresses for bus and cpu
  walkAddrGen addrGen (
    .clk(clk), .reset(reset), .state(state), .cpuRequest(cpuRequest),
    .busy(busy), .cpuAddr(cpuAddr), .tBase(tBase), .busRData(busRData),
    .busReady(busReady), .hitPhysTag(hitPhysTag), .hitSize(hitSize),
    .mmuEnable(mmuEnable), .virtAddr(virtAddr), .busAddr(busAddr),
    .physAddr(physAddr), .fillPhysTag(fillPhysTag), .fillSize(fillSize)
  );

  // translation cache
  tlb tlbArray (
    .clk(clk), .reset(reset), .virtAddr(virtAddr), .tlbWrite(tlbWrite),
    .tlbFlush(tlbFlush), .fillPhysTag(fillPhysTag), .fillSize(fillSize),
    .tlbHit(tlbHit), .hitPhysTag(hitPhysTag), .hitSize(hitSize)
  );

  // FSR/FAR
  faultRegs faults (
    .clk(clk), .reset(reset), .faultWrite(faultWrite), .faultCode(faultCode),
    .virtAddr(virtAddr), .fsr(fsr), .far(far)
  );

endmodule

`default_nettype wire

// ==== bench/mmuTb.sv ====
`default_nettype none

module mmuTb;

  import mmuPkg::*;

  localparam int numRequests = 300;
  // strobe, lookup, two fetches with 3 stalls each, translate, idle, flush
  localparam int worstWalk   = 14;

  logic        clk;
  logic        reset;
  logic        mmuEnable;
  logic        tlbFlush;
  logic        cpuRequest;
  logic [31:0] cpuAddr;
  logic        dataAccess;
  logic [17:0] tBase;
  logic        busy;
  logic        paReady;
  logic [31:0] physAddr;
  logic        prefetchAbort;
  logic        dataAbort;
  logic [3:0]  fsr;
  logic [31:0] far;
  logic        busRequest;
  logic [31:0] busAddr;
  logic [31:0] busRData;
  logic        busReady;

  logic [31:0] lfsrState;
  // va[31:20] and va[19:12] pools, low two bits fixed per slot
  logic [11:0] mbPool   [16];
  logic [7:0]  pagePool [4];
  // reference TLB, entries keep full va/pa and the page shift
  logic        modelValid [tlbEntries];
  logic [31:0] modelVirt  [tlbEntries];
  logic [31:0] modelPhys  [tlbEntries];
  int          modelShift [tlbEntries];
  int          modelPtr;
  logic [3:0]  expFsr;
  logic [31:0] expFar;
  // section, large, small, tiny, data fault, prefetch fault, hit, flat
  int          kinds [8];

  mmuTop DUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #(numRequests * worstWalk * 20);
    $display("Watchdog expired before all requests finished");
    haltRun();
  end

  // ====================================================================
  // failure handling and compares
  // ====================================================================
  task automatic haltRun();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic failWith(input string msg);
    $display("%0t: %s", $time, msg);
    haltRun();
  endtask

  task automatic physAddrEquals(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      haltRun();
    end
  endtask

  task automatic faultCodeEquals(input logic [3:0] got, input logic [3:0] exp,
                                 input string what);
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      haltRun();
    end
  endtask

  task automatic busAddrEquals(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: busAddr is %h, expected %h", $time, got, exp);
      haltRun();
    end
  endtask

  // ====================================================================
  // stimulus and reference model
  // ====================================================================
  // fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      bits      = {bits[30:0], fb};
    end
    return bits;
  endfunction

  // table contents, type bits follow addr[3:2] so every code shows up
  function automatic logic [31:0] tableWord(input logic [31:0] addr);
    logic [31:0] h;
    h = addr * 32'h9e3779b1;
    h = h ^ (h >> 15);
    h = h * 32'h85ebca6b;
    return {h[31:2], addr[3:2]};
  endfunction

  // page base above shift, va below
  function automatic logic [31:0] mergePage(input logic [31:0] base, input logic [31:0] va,
                                            input int shift);
    logic [31:0] mask;
    mask = 32'hffff_ffff << shift;
    return (base & mask) | (va & ~mask);
  endfunction

  // lowest valid entry covering va
  function automatic int modelHit(input logic [31:0] va);
    for (int i = 0; i < tlbEntries; i++) begin
      if (modelValid[i] && ((va >> modelShift[i]) == (modelVirt[i] >> modelShift[i])))
        return i;
    end
    return -1;
  endfunction

  // one request from strobe to the idle cycle after its result
  task automatic runRequest(input logic [31:0] va, input logic isData);
    logic [31:0] expAddr [2];
    logic [31:0] l1;
    logic [31:0] l2;
    logic [31:0] expPhys;
    logic [3:0]  code;
    int          fetches;
    int          fetchIdx;
    int          shift;
    int          hitIdx;
    int          stall;
    int          cycles;
    int          kind;
    bit          walk;
    bit          fault;
    bit          done;
    fetches = 0;
    fetchIdx = 0;
    shift = 10;
    walk = 1'b0;
    fault = 1'b0;
    code = '0;
    l2 = '0;
    expPhys = va;
    hitIdx = modelHit(va);
    if (!mmuEnable) begin
      kind = 7;
    end else if (hitIdx >= 0) begin
      kind = 6;
      expPhys = mergePage(modelPhys[hitIdx], va, modelShift[hitIdx]);
    end else begin
      // first level walk
      walk = 1'b1;
      fetches = 1;
      expAddr[0] = {tBase, va[31:20], 2'b00};
      l1 = tableWord(expAddr[0]);
      case (l1[1:0])
        descSection: begin
          shift = 20;
          kind = 0;
          l2 = l1;
        end
        descCoarse: begin
          fetches = 2;
          expAddr[1] = {l1[31:10], va[19:12], 2'b00};
        end
        descFine: begin
          fetches = 2;
          expAddr[1] = {l1[31:12], va[19:10], 2'b00};
        end
        default: begin
          fault = 1'b1;
          code = fsrSectionFault;
        end
      endcase
      // second level page
      if (fetches == 2) begin
        l2 = tableWord(expAddr[1]);
        case (l2[1:0])
          descLarge: begin
            shift = 16;
            kind = 1;
          end
          descSmall: begin
            shift = 12;
            kind = 2;
          end
          descTiny: begin
            shift = 10;
            kind = 3;
          end
          default: begin
            fault = 1'b1;
            code = fsrPageFault;
          end
        endcase
      end
      if (fault) begin
        kind = isData ? 4 : 5;
        if (isData) begin
          expFsr = code;
          expFar = va;
        end
      end else begin
        expPhys = mergePage(l2, va, shift);
        modelValid[modelPtr] = 1'b1;
        modelVirt[modelPtr] = va;
        modelPhys[modelPtr] = l2;
        modelShift[modelPtr] = shift;
        modelPtr = (modelPtr + 1) % tlbEntries;
      end
    end
    kinds[kind]++;

    cpuRequest = 1'b1;
    cpuAddr = va;
    dataAccess = isData;
    @(posedge clk);
    #2;
    // DUT must work from its own copy of the va and access kind
    cpuRequest = 1'b0;
    cpuAddr = takeBits(32);
    dataAccess = ~isData;
    done = 1'b0;
    cycles = 0;
    stall = takeBits(2);
    while (!done) begin
      cycles++;
      busReady = 1'b0;
      if (cycles > worstWalk)
        failWith("request did not finish");
      if (!busy)
        failWith("busy low while a request is in progress");
      if (paReady || dataAbort || prefetchAbort) begin
        done = 1'b1;
        if (fetchIdx != fetches)
          failWith("walk ended before all descriptors were fetched");
        if (!walk && cycles != 1)
          failWith("hit or flat result not one cycle after the strobe");
        if (fault) begin
          if (paReady || (dataAbort != isData) || (prefetchAbort == isData))
            failWith("wrong abort kind for a translation fault");
        end else begin
          if (!paReady || dataAbort || prefetchAbort)
            failWith("abort raised where a translation was expected");
          physAddrEquals(physAddr, expPhys, "physAddr");
        end
      end else if (busRequest) begin
        if (fetchIdx >= fetches)
          failWith("unexpected descriptor fetch on the bus");
        busAddrEquals(busAddr, expAddr[fetchIdx]);
        if (stall > 0) begin
          // junk data while stalled
          stall--;
          busRData = takeBits(32);
        end else begin
          busReady = 1'b1;
          busRData = tableWord(busAddr);
          fetchIdx++;
          stall = takeBits(2);
        end
      end
      @(posedge clk);
      #2;
    end
    if (busy)
      failWith("busy still high after the result");
    // fault registers settle one edge after faultReport
    faultCodeEquals(fsr, expFsr, "fsr");
    physAddrEquals(far, expFar, "far");
  endtask

  // ====================================================================
  // main sequence
  // ====================================================================
  initial begin
    logic [31:0] pick;
    logic [31:0] va;
    logic [3:0]  mbIdx;
    logic [1:0]  pgIdx;
    lfsrState = 32'hf0333970;
    reset = 1'b1;
    mmuEnable = 1'b1;
    tlbFlush = 1'b0;
    cpuRequest = 1'b0;
    cpuAddr = '0;
    dataAccess = 1'b0;
    busRData = '0;
    busReady = 1'b0;
    pick = takeBits(18);
    tBase = pick[17:0];
    expFsr = '0;
    expFar = '0;
    modelPtr = 0;
    for (int i = 0; i < tlbEntries; i++)
      modelValid[i] = 1'b0;
    for (int i = 0; i < 8; i++)
      kinds[i] = 0;
    for (int i = 0; i < 16; i++) begin
      pick = takeBits(10);
      mbPool[i] = {pick[9:0], i[1:0]};
    end
    for (int i = 0; i < 4; i++) begin
      pick = takeBits(6);
      pagePool[i] = {pick[5:0], i[1:0]};
    end

    repeat (2) @(posedge clk);
    #2;
    if (busy || paReady || busRequest || dataAbort || prefetchAbort)
      failWith("outputs not low during reset");
    faultCodeEquals(fsr, 4'h0, "fsr after reset");
    physAddrEquals(far, 32'h0, "far after reset");
    reset = 1'b0;

    for (int n = 0; n < numRequests; n++) begin
      // occasional flush while idle
      if (takeBits(4) == 0) begin
        tlbFlush = 1'b1;
        @(posedge clk);
        #2;
        tlbFlush = 1'b0;
        for (int i = 0; i < tlbEntries; i++)
          modelValid[i] = 1'b0;
      end
      if (takeBits(3) == 0)
        mmuEnable = ~mmuEnable;
      pick = takeBits(4);
      mbIdx = pick[3:0];
      pick = takeBits(2);
      pgIdx = pick[1:0];
      pick = takeBits(12);
      va = {mbPool[mbIdx], pagePool[pgIdx], pick[11:0]};
      pick = takeBits(1);
      runRequest(va, pick[0]);
    end

    // every translation kind must have come up
    for (int k = 0; k < 8; k++) begin
      if (kinds[k] == 0)
        failWith($sformatf("translation kind %0d never exercised", k));
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/mmuPkg.sv
verilog/tableWalker.sv
verilog/walkAddrGen.sv
verilog/tlb.sv
verilog/faultRegs.sv
verilog/mmuTop.sv
bench/mmuTb.sv

// ==== Bender.yml ====
package:
  name: mmu

sources:
  - verilog/mmuPkg.sv
  - verilog/tableWalker.sv
  - verilog/walkAddrGen.sv
  - verilog/tlb.sv
  - verilog/faultRegs.sv
  - verilog/mmuTop.sv
  - target: simulation
    files:
      - bench/mmuTb.sv
